//--- rtl/uc_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths, instruction word layout, decoded controls and encodings of the cpu
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package uc_pkg;

    parameter int DATA_W = 16;                          // bits per word
    parameter int ADDR_W = 12;                          // microcode address bits

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;

    typedef enum logic [3:0] {
        ALU_NONE = 4'd0,                                // pass arg a
        ALU_ADD  = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_MUL  = 4'd3,                                // low half of product
        ALU_AND  = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_ROL  = 4'd7,                                // rotate left by one
        ALU_FAIL = 4'd14,                               // stop with bad status
        ALU_MEM  = 4'd15                                // memory access, alu bypassed
    } alu_op_e;

    typedef enum logic [2:0] {
        SE_NONE = 3'd0,
        SE_DROP = 3'd1,
        SE_PUSH = 3'd2,
        SE_RPLC = 3'd3,                                 // replace top
        SE_SWAP = 3'd4,
        SE_ROT  = 3'd5                                  // a b c -- b c a
    } stack_se_e;

    typedef enum logic [2:0] {
        RNG_UC  = 3'd0,                                 // microcode memory
        RNG_PC  = 3'd1,                                 // word at pc, then pc+1
        RNG_DEV = 3'd3                                  // output device
    } mem_rng_e;

    typedef enum logic [1:0] {A_TOS, A_NOS, A_TORS, A_ZERO} arg_a_e;
    typedef enum logic [1:0] {B_TOS, B_ONE, B_MSB, B_ONES} arg_b_e;

    // control words keep the target address in the low 12 bits
    typedef struct packed {
        logic       ctrl;                               // control transfer
        logic       r_pc;                               // pc <-> return stack
        logic [1:0] r_op;                               // return op, or branch kind
        logic       d_drop;                             // extra drop in alu phase
        logic [2:0] d_op;                               // data stack effect
        logic [1:0] arg_a;                              // write flag + range msb on mem ops
        logic [1:0] arg_b;
        logic [3:0] alu_op;
    } uc_instr_t;

    typedef struct packed {
        stack_se_e d_se;
        stack_se_e r_se;
        alu_op_e   alu_op;
        arg_a_e    sel_a;
        arg_b_e    sel_b;
        logic      mem_en;                              // instruction is a memory op
        logic      mem_wr;                              // store, alu phase only
        mem_rng_e  mem_rng;
        logic      pc_load;                             // branch taken
        logic      pc_inc;                              // literal fetch
        logic      pc_from_r;                           // return
        logic      r_from_pc;                           // return push takes pc
        logic      fail;
    } uc_ctrl_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
        word_t data;
    } uc_load_t;

endpackage

`default_nettype wire

//--- rtl/uc_mem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// microcode program ram with load port, store port and one registered read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module uc_mem import uc_pkg::*; #(
    parameter int ADDR_W = uc_pkg::ADDR_W               // sets the depth
) (
    input  logic     i_clk,
    input  logic     i_rst,
    input  uc_load_t i_load,                            // loader strobe
    input  logic     i_wr,                              // store from program
    input  addr_t    i_waddr,
    input  word_t    i_wdata,
    input  addr_t    i_raddr,
    output word_t    o_rdata                            // one cycle after i_raddr
);

    word_t mem [0:(1<<ADDR_W)-1];                       // block ram

    always_ff @(posedge i_clk) begin
        if (i_load.valid) begin
            mem[i_load.addr] <= i_load.data;            // loader wins
        end else if (i_wr) begin
            mem[i_waddr] <= i_wdata;
        end else begin
            o_rdata <= mem[i_raddr];                    // read skipped on a write
        end
    end

    // the loader is gated off in the cpu top whenever a store can happen
    a_load_vs_store: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_load.valid && i_wr))
        else $error("load strobe and program store in the same cycle");

endmodule

`default_nettype wire

//--- rtl/uc_stack.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shifting register stack for data and return stacks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module uc_stack import uc_pkg::*; #(
    parameter int DEPTH   = 12,                         // entries, 3 or more
    parameter bit PERM_EN = 1'b1                        // swap/rot expected here
) (
    input  logic      i_clk,
    input  logic      i_rst,
    input  stack_se_e i_se,                             // effect for this cycle
    input  word_t     i_data,                           // push / replace value
    output word_t     o_s0,                             // top
    output word_t     o_s1                              // next
);

    word_t stk [DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stk[i] <= '0;                           // empty stack reads zero
            end
        end else begin
            case (i_se)
                SE_PUSH: begin
                    stk[0] <= i_data;
                    for (int i = 1; i < DEPTH; i++) begin
                        stk[i] <= stk[i-1];             // oldest entry falls off
                    end
                end
                SE_DROP: begin
                    for (int i = 0; i < DEPTH-1; i++) begin
                        stk[i] <= stk[i+1];             // bottom entry repeats
                    end
                end
                SE_RPLC: stk[0] <= i_data;
                SE_SWAP: begin
                    stk[0] <= stk[1];
                    stk[1] <= stk[0];
                end
                SE_ROT: begin
                    stk[0] <= stk[2];
                    stk[1] <= stk[0];
                    stk[2] <= stk[1];
                end
                default: ;                              // none, codes 6 and 7
            endcase
        end
    end

    assign o_s0 = stk[0];
    assign o_s1 = stk[1];

    // decode only hands the return stack two-bit effects
    a_no_perm: assert property (@(posedge i_clk) disable iff (i_rst)
        !PERM_EN |-> !(i_se inside {SE_SWAP, SE_ROT}))
        else $error("swap or rotate on a stack that never permutes");

endmodule

`default_nettype wire

//--- rtl/uc_alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// operand select and registered alu
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module uc_alu import uc_pkg::*; (
    input  logic    i_clk,
    input  alu_op_e i_op,
    input  arg_a_e  i_sel_a,
    input  arg_b_e  i_sel_b,
    input  word_t   i_tos,
    input  word_t   i_nos,
    input  word_t   i_tors,
    output word_t   o_data                              // valid in the next phase
);

    word_t arg_a;
    word_t arg_b;
    word_t result;

    always_comb begin
        case (i_sel_a)
            A_NOS:   arg_a = i_nos;
            A_TORS:  arg_a = i_tors;
            A_ZERO:  arg_a = '0;
            default: arg_a = i_tos;
        endcase
        case (i_sel_b)
            B_ONE:   arg_b = word_t'(1);
            B_MSB:   arg_b = {1'b1, {(DATA_W-1){1'b0}}};   // 16'h8000
            B_ONES:  arg_b = '1;                        // -1
            default: arg_b = i_tos;
        endcase
        case (i_op)
            ALU_ADD: result = arg_a + arg_b;
            ALU_SUB: result = arg_a - arg_b;
            ALU_MUL: result = arg_a * arg_b;            // truncated to a word
            ALU_AND: result = arg_a & arg_b;
            ALU_XOR: result = arg_a ^ arg_b;
            ALU_OR:  result = arg_a | arg_b;
            ALU_ROL: result = {arg_a[DATA_W-2:0], arg_a[DATA_W-1]};
            default: result = arg_a;                    // none, fail, mem
        endcase
    end

    always_ff @(posedge i_clk) begin
        o_data <= result;
    end

endmodule

`default_nettype wire

//--- rtl/uc_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per-phase instruction decode with branch decision and stack effects
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module uc_decode import uc_pkg::*; (
    input  uc_instr_t i_instr,
    input  logic      i_alu_phase,
    input  word_t     i_tos,
    input  word_t     i_tors,
    output uc_ctrl_t  o_ctrl
);

    logic     auto;                                     // test-decrement loop
    logic     branch;
    logic     mem_op;
    mem_rng_e rng;

    always_comb begin
        auto   = i_instr.r_op[1];
        branch = (i_instr.r_op == 2'b00)                // jump / call
              || (i_instr.r_op == 2'b01 && i_tos == '0) // branch if zero
              || (auto && i_tors != '0);                // loop while count nonzero
        mem_op = !i_instr.ctrl && i_instr.alu_op == ALU_MEM;
        case ({i_instr.arg_a[0], i_instr.arg_b})
            3'd1:    rng = RNG_PC;
            3'd3:    rng = RNG_DEV;
            default: rng = RNG_UC;                      // unused ranges map to ram
        endcase

        o_ctrl           = '0;
        o_ctrl.mem_en    = mem_op;
        o_ctrl.mem_wr    = mem_op && i_alu_phase && i_instr.arg_a[1];
        o_ctrl.mem_rng   = rng;
        o_ctrl.pc_load   = i_alu_phase && i_instr.ctrl && branch;
        o_ctrl.pc_inc    = i_alu_phase && mem_op && rng == RNG_PC;
        o_ctrl.pc_from_r = i_alu_phase && !i_instr.ctrl && i_instr.r_pc;
        o_ctrl.r_from_pc = i_instr.ctrl && !auto;       // call pushes return addr
        o_ctrl.fail      = !i_instr.ctrl && i_instr.alu_op == ALU_FAIL;

        if (i_instr.ctrl) begin
            o_ctrl.alu_op = ALU_ADD;                    // tors +/- 1 for the loop
            o_ctrl.sel_a  = A_TORS;
            o_ctrl.sel_b  = arg_b_e'({i_instr.r_op[0], 1'b1});
            if (i_alu_phase) begin
                o_ctrl.r_se = (!auto && i_instr.r_pc) ? SE_PUSH : SE_NONE;
            end else begin
                o_ctrl.d_se = (i_instr.r_op == 2'b01) ? SE_DROP : SE_NONE;   // pop cond
                if (auto) begin
                    o_ctrl.r_se = (i_tors == '0) ? SE_DROP : SE_RPLC;
                end
            end
        end else begin
            o_ctrl.alu_op = alu_op_e'(i_instr.alu_op);
            o_ctrl.sel_a  = arg_a_e'(i_instr.arg_a);
            o_ctrl.sel_b  = arg_b_e'(i_instr.arg_b);
            if (i_alu_phase) begin
                o_ctrl.d_se = (i_instr.d_drop || o_ctrl.mem_wr) ? SE_DROP : SE_NONE;
            end else begin
                o_ctrl.d_se = (i_instr.d_op > 3'd5) ? SE_NONE : stack_se_e'(i_instr.d_op);
                o_ctrl.r_se = stack_se_e'({1'b0, i_instr.r_op});
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/uc_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-phase sequencer with pc, instruction register, status and halt
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module uc_sequencer import uc_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_run,
    input  uc_ctrl_t  i_ctrl,
    input  word_t     i_rdata,                          // fetched word
    input  word_t     i_tors,                           // return address
    output uc_instr_t o_instr,
    output logic      o_alu_phase,
    output logic      o_running,
    output logic      o_status,
    output addr_t     o_pc
);

    typedef enum logic {PH_STACK, PH_ALU} phase_e;

    phase_e    phase;
    uc_instr_t instr_r;                                 // held for the stack phase
    addr_t     pc;
    logic      halt;
    logic      self_jump;

    // the word fetched during the stack phase is decoded straight from ram
    assign o_instr     = (phase == PH_ALU) ? uc_instr_t'(i_rdata) : instr_r;
    assign o_alu_phase = (phase == PH_ALU);
    assign o_running   = i_run && o_status && !halt;
    assign o_pc        = pc;

    // pc already points past the jump here
    assign self_jump = i_ctrl.pc_load && o_instr.r_op == 2'b00 && !o_instr.r_pc
                    && o_instr[ADDR_W-1:0] == pc - 1'b1;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            phase    <= PH_STACK;
            instr_r  <= '0;                             // nop
            pc       <= '0;
            o_status <= 1'b1;
            halt     <= 1'b0;
        end else if (i_ctrl.fail) begin
            phase    <= PH_STACK;
            instr_r  <= '0;
            o_status <= 1'b0;                           // sticky until reset
        end else if (phase == PH_ALU) begin
            if (i_ctrl.pc_from_r) begin
                pc <= i_tors[ADDR_W-1:0];
            end else if (i_ctrl.pc_inc) begin
                pc <= pc + 1'b1;                        // skip the literal
            end else if (i_ctrl.pc_load) begin
                pc <= o_instr[ADDR_W-1:0];
            end
            if (self_jump) begin
                halt <= 1'b1;                           // idle loop ends the run
            end
            instr_r <= o_instr;
            phase   <= PH_STACK;
        end else if (o_running) begin
            pc    <= pc + 1'b1;                         // next fetch
            phase <= PH_ALU;
        end
    end

    // a fail seen in the stack phase would stall the pair
    a_phase_toggle: assert property (@(posedge i_clk) disable iff (i_rst)
        o_running |=> (o_alu_phase != $past(o_alu_phase)))
        else $error("phases did not alternate while running");

endmodule

`default_nettype wire

//--- rtl/uc_cpu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cpu top with memory, stacks, alu, decode, sequencer and output strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module uc_cpu import uc_pkg::*; #(
    parameter int DSTACK_DEPTH = 12,
    parameter int RSTACK_DEPTH = 8
) (
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_run,
    input  uc_load_t i_load,                            // program loader
    output logic     o_running,
    output logic     o_status,                          // low after a fail
    output logic     o_out_valid,                       // one-cycle strobe
    output word_t    o_out_data
);

    uc_ctrl_t  ctrl;
    uc_instr_t instr;
    uc_load_t  load;
    logic      alu_phase;
    logic      step;                                    // stack phase may act
    logic      uc_wr;
    logic      dev_wr;
    addr_t     pc;
    addr_t     raddr;
    word_t     rdata, alu_out, tos, nos, tors;
    word_t     d_value, r_value;
    stack_se_e d_se, r_se;

    // a stack phase waiting on i_run must not repeat its effect
    assign step   = alu_phase || o_running;
    assign d_se   = step ? ctrl.d_se : SE_NONE;
    assign r_se   = step ? ctrl.r_se : SE_NONE;

    assign uc_wr  = ctrl.mem_wr && ctrl.mem_rng == RNG_UC;
    assign dev_wr = ctrl.mem_wr && ctrl.mem_rng == RNG_DEV;
    assign raddr  = (alu_phase && ctrl.mem_en && ctrl.mem_rng == RNG_UC)
                  ? tos[ADDR_W-1:0] : pc;               // fetch or literal otherwise
    assign d_value = ctrl.mem_en ? rdata : alu_out;
    assign r_value = ctrl.r_from_pc ? {{(DATA_W-ADDR_W){1'b0}}, pc} : d_value;

    always_comb begin
        load       = i_load;
        load.valid = i_load.valid && !o_running && !alu_phase;   // idle only
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_out_valid <= 1'b0;
        end else begin
            o_out_valid <= dev_wr;
        end
        if (dev_wr) begin
            o_out_data <= nos;                          // value under the address
        end
    end

    uc_mem #(.ADDR_W(ADDR_W)) uc_mem_inst (
        .i_clk(i_clk), .i_rst(i_rst), .i_load(load),
        .i_wr(uc_wr), .i_waddr(tos[ADDR_W-1:0]), .i_wdata(nos),
        .i_raddr(raddr), .o_rdata(rdata)
    );

    uc_stack #(.DEPTH(DSTACK_DEPTH)) d_stack_inst (
        .i_clk(i_clk), .i_rst(i_rst), .i_se(d_se), .i_data(d_value),
        .o_s0(tos), .o_s1(nos)
    );

    uc_stack #(.DEPTH(RSTACK_DEPTH), .PERM_EN(1'b0)) r_stack_inst (
        .i_clk(i_clk), .i_rst(i_rst), .i_se(r_se), .i_data(r_value),
        .o_s0(tors), .o_s1()
    );

    uc_alu uc_alu_inst (
        .i_clk(i_clk), .i_op(ctrl.alu_op), .i_sel_a(ctrl.sel_a), .i_sel_b(ctrl.sel_b),
        .i_tos(tos), .i_nos(nos), .i_tors(tors), .o_data(alu_out)
    );

    uc_decode uc_decode_inst (
        .i_instr(instr), .i_alu_phase(alu_phase), .i_tos(tos), .i_tors(tors),
        .o_ctrl(ctrl)
    );

    uc_sequencer uc_sequencer_inst (
        .i_clk(i_clk), .i_rst(i_rst), .i_run(i_run), .i_ctrl(ctrl),
        .i_rdata(rdata), .i_tors(tors), .o_instr(instr), .o_alu_phase(alu_phase),
        .o_running(o_running), .o_status(o_status), .o_pc(pc)
    );

endmodule

`default_nettype wire

//--- verif/tb_uc_cpu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cpu testbench with program loader, lcg, alu reference and output checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module tb_uc_cpu import uc_pkg::*; ();

    localparam int N_PAIRS     = 20;
    localparam int T1_WORDS    = 8 * 7 + 1;                 // 2 lits, op, dup, st per op
    localparam int ALL_WORDS   = N_PAIRS * T1_WORDS + 20 + 26 + 8 + 11 + 10;
    localparam int LOOP_RUNS   = 9 * 4;                     // loop body reruns at N = 8
    // a word loads in one cycle and runs in two, each test adds reset and tail
    localparam int CYCLE_LIMIT = 2 * (3 * (ALL_WORDS + LOOP_RUNS) + 14 * (N_PAIRS + 5));

    logic     i_clk, i_rst, i_run;
    uc_load_t load_in;
    logic     o_running, o_status, o_out_valid;
    word_t    o_out_data;

    word_t       prog [$];                                  // program image
    word_t       exp_q [$];                                 // expected device words
    logic [31:0] rng;
    string       test_name;
    int          cycle_cnt = 0;

    uc_cpu #(.DSTACK_DEPTH(12), .RSTACK_DEPTH(8)) uc_cpu_inst (
        .i_clk(i_clk), .i_rst(i_rst), .i_run(i_run), .i_load(load_in),
        .o_running(o_running), .o_status(o_status),
        .o_out_valid(o_out_valid), .o_out_data(o_out_data)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;                         // 20 ns period
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // a is the first operand (next on stack), b the second (top)
    function automatic word_t ref_alu(input alu_op_e op, input word_t a, input word_t b);
        word_t r;
        case (op)
            ALU_ADD: r = a + b;
            ALU_SUB: r = a - b;
            ALU_MUL: r = a * b;                             // low half kept
            ALU_AND: r = a & b;
            ALU_XOR: r = a ^ b;
            ALU_OR:  r = a | b;
            ALU_ROL: r = {a[DATA_W-2:0], a[DATA_W-1]};
            default: r = a;
        endcase
        return r;
    endfunction

    function automatic word_t op_word(input logic rpc, input logic [1:0] rop, input logic ddrop,
                                      input stack_se_e dop, input logic [1:0] sa,
                                      input logic [1:0] sb, input alu_op_e op);
        uc_instr_t w;
        w        = '0;
        w.r_pc   = rpc;
        w.r_op   = rop;
        w.d_drop = ddrop;
        w.d_op   = dop;
        w.arg_a  = sa;
        w.arg_b  = sb;
        w.alu_op = op;
        return word_t'(w);
    endfunction

    function automatic word_t ctrl_word(input logic rpc, input logic [1:0] rop, input addr_t tgt);
        uc_instr_t w;
        w      = uc_instr_t'({{(DATA_W-ADDR_W){1'b0}}, tgt});   // target in low bits
        w.ctrl = 1'b1;
        w.r_pc = rpc;
        w.r_op = rop;
        return word_t'(w);
    endfunction

    task automatic add_word(input word_t w);
        prog.push_back(w);
    endtask

    task automatic lit(input word_t v);
        add_word(op_word(1'b0, 2'b00, 1'b0, SE_PUSH, 2'b00, 2'b01, ALU_MEM));   // pc range
        add_word(v);
    endtask

    // dup, then device store that eats address and value
    task automatic emit_top();
        add_word(op_word(1'b0, 2'b00, 1'b0, SE_PUSH, 2'b00, 2'b00, ALU_NONE));
        add_word(op_word(1'b0, 2'b00, 1'b0, SE_DROP, 2'b10, 2'b11, ALU_MEM));
    endtask

    task automatic halt_here();
        add_word(ctrl_word(1'b0, 2'b00, addr_t'(prog.size())));     // jump to itself
    endtask

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_error(input string msg);
        $display("error in %s: %s", test_name, msg);
        abort_run();
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    // reset, load through the strobe port, run until halt or fail
    task automatic run_program(input logic exp_status);
        i_rst = 1'b1;
        repeat (8) @(negedge i_clk);
        i_rst = 1'b0;
        for (int i = 0; i < prog.size(); i++) begin
            @(negedge i_clk);
            load_in.valid = 1'b1;
            load_in.addr  = addr_t'(i);
            load_in.data  = prog[i];
        end
        @(negedge i_clk);
        load_in.valid = 1'b0;
        i_run = 1'b1;
        do begin
            @(negedge i_clk);
        end while (o_running);
        repeat (4) @(negedge i_clk);                        // let late strobes show
        check_bit({test_name, " running"}, 1'b0, o_running);   // stays stopped, i_run high
        i_run = 1'b0;
        @(negedge i_clk);
        check_bit({test_name, " status"}, exp_status, o_status);
        if (exp_q.size() != 0) begin
            report_error("program halted with expected outputs missing");
        end
        prog.delete();
    endtask

    // o_out_valid is registered, stable at the falling edge
    always @(negedge i_clk) begin
        if (o_out_valid) begin
            if (exp_q.size() == 0) begin
                report_error("output strobe with no word expected");
            end else begin
                check_word(test_name, exp_q.pop_front(), o_out_data);
            end
        end
    end

    always @(posedge i_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the DUT did not finish", cycle_cnt);
            abort_run();
        end
    end

    initial begin
        word_t a, b, v;
        int    n;
        i_rst   = 1'b1;
        i_run   = 1'b0;
        load_in = '0;
        rng     = 32'h82c0;

        for (int p = 0; p < N_PAIRS; p++) begin
            test_name = $sformatf("alu pair %0d", p);
            rng = lcg(rng);
            a   = rng[31:16];
            rng = lcg(rng);
            b   = rng[31:16];
            for (int k = 0; k < 8; k++) begin               // none .. rol
                lit(a);
                lit(b);
                add_word(op_word(1'b0, 2'b00, 1'b1, SE_RPLC, 2'b01, 2'b00, alu_op_e'(k)));
                emit_top();
                exp_q.push_back(ref_alu(alu_op_e'(k), a, b));
            end
            halt_here();
            run_program(1'b1);
        end

        test_name = "stack ops";
        lit(16'h1111);
        lit(16'h2222);
        lit(16'h3333);
        add_word(op_word(1'b0, 2'b00, 1'b0, SE_ROT, 2'b00, 2'b00, ALU_NONE));    // y z x
        add_word(op_word(1'b0, 2'b00, 1'b0, SE_SWAP, 2'b00, 2'b00, ALU_NONE));   // y x z
        add_word(op_word(1'b0, 2'b00, 1'b0, SE_PUSH, 2'b01, 2'b00, ALU_NONE));   // over
        add_word(op_word(1'b0, 2'b00, 1'b0, SE_PUSH, 2'b00, 2'b00, ALU_NONE));   // dup
        add_word(op_word(1'b0, 2'b00, 1'b0, SE_DROP, 2'b00, 2'b00, ALU_NONE));
        repeat (4) emit_top();
        halt_here();
        exp_q = '{16'h1111, 16'h3333, 16'h1111, 16'h2222};  // top first
        run_program(1'b1);

        test_name = "call and branch";
        add_word(ctrl_word(1'b1, 2'b00, 12'd23));           // 0: call sub
        emit_top();                                         // 1
        lit(16'h0000);                                      // 3
        add_word(ctrl_word(1'b0, 2'b01, 12'd10));           // 5: bz, taken
        lit(16'hbad1);                                      // 6
        emit_top();                                         // 8
        lit(16'h0005);                                      // 10
        add_word(ctrl_word(1'b0, 2'b01, 12'd18));           // 12: bz, not taken
        lit(16'h600d);                                      // 13
        emit_top();                                         // 15
        halt_here();                                        // 17
        lit(16'hbad2);                                      // 18
        emit_top();                                         // 20
        halt_here();                                        // 22
        lit(16'h4b1d);                                      // 23: sub pushes constant
        add_word(op_word(1'b1, 2'b01, 1'b0, SE_NONE, 2'b00, 2'b00, ALU_NONE));   // ret
        exp_q = '{16'h4b1d, 16'h600d};
        run_program(1'b1);

        test_name = "decrement loop";
        rng = lcg(rng);
        n   = 1 + rng[18:16];                               // 1 to 8
        lit(word_t'(n));
        add_word(op_word(1'b0, 2'b10, 1'b0, SE_DROP, 2'b00, 2'b00, ALU_NONE));   // >r
        add_word(op_word(1'b0, 2'b00, 1'b0, SE_PUSH, 2'b10, 2'b00, ALU_NONE));   // 3: r@
        emit_top();
        add_word(ctrl_word(1'b0, 2'b11, 12'd3));            // loop while count nonzero
        halt_here();
        for (int i = n; i >= 0; i--) begin
            exp_q.push_back(word_t'(i));
        end
        run_program(1'b1);

        test_name = "store and fetch";
        rng = lcg(rng);
        v   = rng[31:16];
        a   = word_t'(12'h800 | rng[7:0]);                  // clear of the program
        lit(v);
        lit(a);
        add_word(op_word(1'b0, 2'b00, 1'b0, SE_DROP, 2'b10, 2'b00, ALU_MEM));    // store
        lit(a);
        add_word(op_word(1'b0, 2'b00, 1'b0, SE_RPLC, 2'b00, 2'b00, ALU_MEM));    // fetch
        emit_top();
        halt_here();
        exp_q.push_back(v);
        run_program(1'b1);

        test_name = "fail";
        lit(16'h0f0f);
        emit_top();
        add_word(op_word(1'b0, 2'b00, 1'b0, SE_NONE, 2'b00, 2'b00, ALU_FAIL));
        lit(16'hdead);                                      // must never come out
        emit_top();
        halt_here();
        exp_q.push_back(16'h0f0f);
        run_program(1'b0);

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
rtl/uc_pkg.sv
rtl/uc_mem.sv
rtl/uc_stack.sv
rtl/uc_alu.sv
rtl/uc_decode.sv
rtl/uc_sequencer.sv
rtl/uc_cpu.sv
verif/tb_uc_cpu.sv
